// File: Makefile
SIM        ?= verilator
TOP        ?= tb_decode_operands
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
hw/frv_pkg.sv
hw/gpr_file.sv
hw/hazard_detect.sv
hw/operand_select.sv
hw/decode_operands.sv
verif/clk_gen.sv
verif/tb_decode_operands.sv

// File: hw/decode_operands.sv
// --------------------
// Decode operand supply
// Register file, hazard compare and forwarding for the decode stage
// of the five-stage pipeline; all outputs are combinational
// --------------------

`default_nettype none

module decode_operands
    import frv_pkg::*;
(
    input  wire logic      g_clk,     // Core clock
    input  wire logic      rst,       // Sync reset, active high
    input  wire reg_addr_t rs1_addr,  // Decode source 1
    input  wire reg_addr_t rs2_addr,  // Decode source 2
    input  wire logic      s1_valid,  // Decode holds an instruction
    input  wire logic      s2_busy,   // Execute is busy
    input  wire reg_addr_t s2_rd,     // Execute destination
    input  wire word_t     s2_wdata,  // Execute result
    input  wire logic      s2_load,   // Load in execute
    input  wire logic      s2_csr,    // CSR op in execute
    input  wire reg_addr_t s3_rd,     // Memory destination
    input  wire word_t     s3_wdata,  // Memory result
    input  wire logic      s3_load,   // Load in memory
    input  wire logic      s3_csr,    // CSR op in memory
    input  wire logic      s4_load,   // Load in writeback
    input  wire logic      s4_csr,    // CSR op in writeback
    input  wire logic      gpr_wen,   // GPR write enable
    input  wire reg_addr_t gpr_rd,    // GPR write address
    input  wire word_t     gpr_wdata, // GPR write data
    output word_t          rs1_data,  // Operand 1 to decode
    output word_t          rs2_data,  // Operand 2 to decode
    output logic           bubble     // Hold decode
);

    // --------------------
    // Internal wiring

    word_t      rs1_rdata; // Raw register file reads
    word_t      rs2_rdata;
    stage_hit_t rs1_hit;   // Per-stage address matches
    stage_hit_t rs2_hit;

    // --------------------
    // Register file

    gpr_file gpr_file_i (
        .g_clk     (g_clk),
        .rst       (rst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .wen       (gpr_wen),   // Writeback port
        .rd_addr   (gpr_rd),
        .rd_wdata  (gpr_wdata),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    // --------------------
    // Hazard compare

    hazard_detect hazard_detect_i (
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .s2_rd    (s2_rd),
        .s3_rd    (s3_rd),
        .gpr_wen  (gpr_wen),  // s4 valid only while writing
        .gpr_rd   (gpr_rd),
        .rs1_hit  (rs1_hit),
        .rs2_hit  (rs2_hit)
    );

    // --------------------
    // Forwarding and bubble

    operand_select operand_select_i (
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .rs1_hit   (rs1_hit),
        .rs2_hit   (rs2_hit),
        .s2_wdata  (s2_wdata),
        .s3_wdata  (s3_wdata),
        .gpr_wdata (gpr_wdata), // Same-cycle write bypass
        .s1_valid  (s1_valid),
        .s2_busy   (s2_busy),
        .s2_load   (s2_load),
        .s3_load   (s3_load),
        .s4_load   (s4_load),
        .s2_csr    (s2_csr),
        .s3_csr    (s3_csr),
        .s4_csr    (s4_csr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .bubble    (bubble)
    );

endmodule

`default_nettype wire

// File: hw/frv_pkg.sv
// --------------------
// Decode operand package
// Pipeline widths, register count and the stage-hit vector type
// shared by the register file, hazard detection and forwarding logic
// --------------------

`default_nettype none

package frv_pkg;

    // --------------------
    // Widths and counts

    localparam int XLEN       = 32; // Data word width
    localparam int REG_ADDR_W = 5;  // GPR address width
    localparam int NUM_REGS   = 32; // x0 .. x31
    localparam int FWD_STAGES = 3;  // s2, s3 and s4 checked

    // Position of each downstream stage in a hit vector
    localparam int HIT_S2 = 0; // Execute
    localparam int HIT_S3 = 1; // Memory
    localparam int HIT_S4 = 2; // Writeback

    // --------------------
    // Shared types

    typedef logic [XLEN-1:0]       word_t;      // One data word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // GPR address
    typedef logic [FWD_STAGES-1:0] stage_hit_t; // One flag per stage

endpackage

`default_nettype wire

// File: hw/gpr_file.sv
// --------------------
// General purpose register file
// 31 writable words plus hard-wired x0, two combinational read
// ports and one write port that lands on the clock edge
// --------------------

`default_nettype none

module gpr_file
    import frv_pkg::*;
(
    input  wire logic      g_clk,     // Core clock
    input  wire logic      rst,       // Sync reset, active high
    input  wire reg_addr_t rs1_addr,  // Source 1 address
    input  wire reg_addr_t rs2_addr,  // Source 2 address
    input  wire logic      wen,       // Write enable
    input  wire reg_addr_t rd_addr,   // Destination address
    input  wire word_t     rd_wdata,  // Write data
    output word_t          rs1_rdata, // Source 1 read data
    output word_t          rs2_rdata  // Source 2 read data
);

    // --------------------
    // Storage

    word_t regs [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0; // Clear every writable register
            end
        end else if (wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_wdata; // Writes to x0 dropped
        end
    end

    // --------------------
    // Read ports

    // x0 decoded here so the array is never indexed at zero
    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // --------------------
    // Checks

    // A write aimed at x0 leaves every word a held read port sees unchanged
    a_x0_write_dropped: assert property (
        @(posedge g_clk) disable iff (rst)
        (wen && (rd_addr == '0)) |=>
            (!$stable(rs1_addr) || $stable(rs1_rdata)) &&
            (!$stable(rs2_addr) || $stable(rs2_rdata))
    );

endmodule

`default_nettype wire

// File: hw/hazard_detect.sv
// --------------------
// Data hazard detection
// Compares both decode source addresses with the destinations held
// in execute, memory and writeback; one hit vector per source
// --------------------

`default_nettype none

module hazard_detect
    import frv_pkg::*;
(
    input  wire reg_addr_t rs1_addr, // Decode source 1
    input  wire reg_addr_t rs2_addr, // Decode source 2
    input  wire reg_addr_t s2_rd,    // Execute destination
    input  wire reg_addr_t s3_rd,    // Memory destination
    input  wire logic      gpr_wen,  // Writeback is writing
    input  wire reg_addr_t gpr_rd,   // Writeback destination
    output stage_hit_t     rs1_hit,  // Source 1 hits per stage
    output stage_hit_t     rs2_hit   // Source 2 hits per stage
);

    // --------------------
    // Address compare

    // x0 is never a real dependency, so a zero source never matches
    function automatic logic addr_match(reg_addr_t src, reg_addr_t dst);
        return (src == dst) && (src != '0);
    endfunction

    logic rs1_s2; // Source 1 vs execute
    logic rs1_s3; // Source 1 vs memory
    logic rs1_s4; // Source 1 vs writeback
    logic rs2_s2; // Source 2 vs execute
    logic rs2_s3; // Source 2 vs memory
    logic rs2_s4; // Source 2 vs writeback

    assign rs1_s2 = addr_match(rs1_addr, s2_rd);
    assign rs1_s3 = addr_match(rs1_addr, s3_rd);
    assign rs1_s4 = addr_match(rs1_addr, gpr_rd) && gpr_wen; // Live write only

    assign rs2_s2 = addr_match(rs2_addr, s2_rd);
    assign rs2_s3 = addr_match(rs2_addr, s3_rd);
    assign rs2_s4 = addr_match(rs2_addr, gpr_rd) && gpr_wen;

    // --------------------
    // Hit vectors

    always_comb begin
        rs1_hit         = '0;
        rs1_hit[HIT_S2] = rs1_s2; // Newest result
        rs1_hit[HIT_S3] = rs1_s3;
        rs1_hit[HIT_S4] = rs1_s4; // Oldest in flight
    end

    always_comb begin
        rs2_hit         = '0;
        rs2_hit[HIT_S2] = rs2_s2;
        rs2_hit[HIT_S3] = rs2_s3;
        rs2_hit[HIT_S4] = rs2_s4;
    end

    // --------------------
    // Checks

    always_comb begin
        a_rs1_zero_no_hit: assert #0 ((rs1_addr != '0) || (rs1_hit == '0));
        a_rs2_zero_no_hit: assert #0 ((rs2_addr != '0) || (rs2_hit == '0));
    end

endmodule

`default_nettype wire

// File: hw/operand_select.sv
// --------------------
// Operand forwarding and bubble
// Picks the newest in-flight value for each source and decides
// whether decode has to hold this cycle
// --------------------

`default_nettype none

module operand_select
    import frv_pkg::*;
(
    input  wire word_t      rs1_rdata, // Register file source 1
    input  wire word_t      rs2_rdata, // Register file source 2
    input  wire stage_hit_t rs1_hit,   // Source 1 stage hits
    input  wire stage_hit_t rs2_hit,   // Source 2 stage hits
    input  wire word_t      s2_wdata,  // Execute result
    input  wire word_t      s3_wdata,  // Memory result
    input  wire word_t      gpr_wdata, // Writeback result
    input  wire logic       s1_valid,  // Decode holds an instruction
    input  wire logic       s2_busy,   // Execute is busy
    input  wire logic       s2_load,   // Load in execute
    input  wire logic       s3_load,   // Load in memory
    input  wire logic       s4_load,   // Load in writeback
    input  wire logic       s2_csr,    // CSR op in execute
    input  wire logic       s3_csr,    // CSR op in memory
    input  wire logic       s4_csr,    // CSR op in writeback
    output word_t           rs1_data,  // Forwarded source 1
    output word_t           rs2_data,  // Forwarded source 2
    output logic            bubble     // Decode must hold
);

    // --------------------
    // Forwarding mux

    // Youngest stage wins, register file is the fallback
    function automatic word_t pick_operand(
        stage_hit_t hit,
        word_t      s2_val,
        word_t      s3_val,
        word_t      s4_val,
        word_t      rf_val
    );
        if (hit[HIT_S2]) return s2_val;
        if (hit[HIT_S3]) return s3_val;
        if (hit[HIT_S4]) return s4_val;
        return rf_val;
    endfunction

    assign rs1_data = pick_operand(rs1_hit, s2_wdata, s3_wdata, gpr_wdata, rs1_rdata);
    assign rs2_data = pick_operand(rs2_hit, s2_wdata, s3_wdata, gpr_wdata, rs2_rdata);

    // --------------------
    // Bubble terms

    logic bubble_no_instr; // Nothing to decode
    logic bubble_from_s2;  // Load or CSR hazard in execute
    logic bubble_from_s3;  // Same for memory
    logic bubble_from_s4;  // Same for writeback

    assign bubble_no_instr = !s1_valid && !s2_busy;

    // Load data not ready yet; CSR ops always serialise
    assign bubble_from_s2 = s2_csr || (s2_load && (rs1_hit[HIT_S2] || rs2_hit[HIT_S2]));
    assign bubble_from_s3 = s3_csr || (s3_load && (rs1_hit[HIT_S3] || rs2_hit[HIT_S3]));
    assign bubble_from_s4 = s4_csr || (s4_load && (rs1_hit[HIT_S4] || rs2_hit[HIT_S4]));

    assign bubble = bubble_no_instr || bubble_from_s2 || bubble_from_s3 || bubble_from_s4;

    // --------------------
    // Checks

    // Quiet pipeline means only an empty decode can stall
    always_comb begin
        a_idle_bubble: assert #0 (
            s2_load || s3_load || s4_load ||
            s2_csr  || s3_csr  || s4_csr  ||
            (rs1_hit != '0) || (rs2_hit != '0) ||
            (bubble == (!s1_valid && !s2_busy))
        );
    end

endmodule

`default_nettype wire

// File: verif/clk_gen.sv
// --------------------
// Testbench clock source
// Free-running clock, 40 time units per period
// --------------------

`default_nettype none

module clk_gen (
    output logic clk // Testbench clock
);

    localparam int HALF_PERIOD = 20; // Half of the 40-unit period

    initial clk = 1'b0; // Low at time zero

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: verif/tb_decode_operands.sv
// --------------------
// Testbench for decode_operands
// Steps a table of stimulus rows through the DUT and compares the
// forwarded operands and the bubble against hand-worked values
// --------------------

`default_nettype none

module tb_decode_operands
    import frv_pkg::*;
;

    localparam int CLK_PERIOD   = 40; // Matches clk_gen
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;  // Inputs change just after the edge
    localparam int CHECK_DELAY  = 28; // Outputs sampled well before next edge

    // --------------------
    // Stimulus row

    typedef struct {
        logic       wen;        // Writeback port
        reg_addr_t  rd;
        word_t      wdata;
        reg_addr_t  rs1;        // Decode sources
        reg_addr_t  rs2;
        logic [1:0] ctl;        // {s1_valid, s2_busy}
        reg_addr_t  s2_rd;      // Execute stage
        word_t      s2_wdata;
        reg_addr_t  s3_rd;      // Memory stage
        word_t      s3_wdata;
        stage_hit_t ld;         // Load flags, bit 0 is s2
        stage_hit_t csr;        // CSR flags, bit 0 is s2
        word_t      exp_rs1;    // Expected outputs
        word_t      exp_rs2;
        logic       exp_bubble;
    } row_t;

    row_t rows[$];            // The table
    bit   table_ready = 1'b0; // Watchdog starts once length is known

    // --------------------
    // DUT signals

    logic      g_clk;
    logic      rst;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      s1_valid;
    logic      s2_busy;
    reg_addr_t s2_rd;
    word_t     s2_wdata;
    logic      s2_load;
    logic      s2_csr;
    reg_addr_t s3_rd;
    word_t     s3_wdata;
    logic      s3_load;
    logic      s3_csr;
    logic      s4_load;
    logic      s4_csr;
    logic      gpr_wen;
    reg_addr_t gpr_rd;
    word_t     gpr_wdata;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      bubble;

    clk_gen clk_gen_i (.clk(g_clk));

    decode_operands decode_operands_i (
        .g_clk (g_clk), .rst (rst), .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .s1_valid (s1_valid), .s2_busy (s2_busy),
        .s2_rd (s2_rd), .s2_wdata (s2_wdata), .s2_load (s2_load), .s2_csr (s2_csr),
        .s3_rd (s3_rd), .s3_wdata (s3_wdata), .s3_load (s3_load), .s3_csr (s3_csr),
        .s4_load (s4_load), .s4_csr (s4_csr),
        .gpr_wen (gpr_wen), .gpr_rd (gpr_rd), .gpr_wdata (gpr_wdata),
        .rs1_data (rs1_data), .rs2_data (rs2_data), .bubble (bubble)
    );

    // --------------------
    // Helpers

    task automatic add_row(logic wen, reg_addr_t rd, word_t wdata, reg_addr_t rs1,
                           reg_addr_t rs2, logic [1:0] ctl, reg_addr_t s2r, word_t s2d,
                           reg_addr_t s3r, word_t s3d, stage_hit_t ld, stage_hit_t csr,
                           word_t e1, word_t e2, logic eb);
        rows.push_back('{wen, rd, wdata, rs1, rs2, ctl, s2r, s2d, s3r, s3d, ld, csr,
                         e1, e2, eb});
    endtask

    task automatic apply_row(row_t r);
        gpr_wen   = r.wen;
        gpr_rd    = r.rd;
        gpr_wdata = r.wdata;
        rs1_addr  = r.rs1;
        rs2_addr  = r.rs2;
        s1_valid  = r.ctl[1];
        s2_busy   = r.ctl[0];
        s2_rd     = r.s2_rd;
        s2_wdata  = r.s2_wdata;
        s3_rd     = r.s3_rd;
        s3_wdata  = r.s3_wdata;
        s2_load   = r.ld[HIT_S2];
        s3_load   = r.ld[HIT_S3];
        s4_load   = r.ld[HIT_S4];
        s2_csr    = r.csr[HIT_S2];
        s3_csr    = r.csr[HIT_S3];
        s4_csr    = r.csr[HIT_S4];
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(string name, word_t got, word_t exp, int row);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: got 0x%h expected 0x%h",
                                row, name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp, int row);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] row %0d %s: got 0x%h expected 0x%h",
                                row, name, got, exp));
        end
    endtask

    // --------------------
    // Table columns wen rd wdata rs1 rs2 ctl s2_rd s2_wdata s3_rd s3_wdata ld csr exp1 exp2 bub

    task automatic build_table();
        // Reset contents, every register read once
        for (int r = 1; r < NUM_REGS; r += 2) begin
            add_row(1'b0, 5'd0, 32'h0, reg_addr_t'(r), reg_addr_t'((r + 1) % NUM_REGS),
                    2'b10, 5'd0, 32'h0, 5'd0, 32'h0, 3'b000, 3'b000, 32'h0, 32'h0, 1'b0);
        end
        // x0
        add_row(1'b1, 5'd0, 32'hDEAD_BEEF, 5'd0, 5'd0, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0, 32'h0, 1'b0); // Write x0, no forward from x0
        add_row(1'b0, 5'd0, 32'h0, 5'd0, 5'd0, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0, 32'h0, 1'b0);
        // Write then read back
        add_row(1'b1, 5'd5, 32'h0000_0505, 5'd6, 5'd7, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0, 32'h0, 1'b0);
        add_row(1'b1, 5'd6, 32'h0000_0606, 5'd5, 5'd0, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0000_0505, 32'h0, 1'b0);
        add_row(1'b1, 5'd7, 32'h0000_0707, 5'd6, 5'd5, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0000_0606, 32'h0000_0505, 1'b0);
        add_row(1'b0, 5'd0, 32'h0, 5'd7, 5'd6, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h0000_0707, 32'h0000_0606, 1'b0);
        // Forwarding priority on x5
        add_row(1'b1, 5'd5, 32'h5555_0004, 5'd5, 5'd5, 2'b10, 5'd5, 32'h2222_0002,
                5'd5, 32'h3333_0003, 3'b000, 3'b000, 32'h2222_0002, 32'h2222_0002, 1'b0);
        add_row(1'b1, 5'd5, 32'h5555_0044, 5'd5, 5'd6, 2'b10, 5'd0, 32'h2222_0002,
                5'd5, 32'h3333_0003, 3'b000, 3'b000, 32'h3333_0003, 32'h0000_0606, 1'b0);
        add_row(1'b1, 5'd5, 32'h5555_0444, 5'd5, 5'd5, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h5555_0444, 32'h5555_0444, 1'b0); // Same-cycle bypass
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b10, 5'd9, 32'h9999_9999, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h5555_0444, 32'h0000_0707, 1'b0);
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b10, 5'd7, 32'hAAAA_0007, 5'd5,
                32'hBBBB_0005, 3'b000, 3'b000, 32'hBBBB_0005, 32'hAAAA_0007, 1'b0);
        // Load hazards
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd6, 2'b10, 5'd5, 32'hC0DE_0002, 5'd0, 32'h0,
                3'b001, 3'b000, 32'hC0DE_0002, 32'h0000_0606, 1'b1);
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd6, 2'b10, 5'd0, 32'h0, 5'd6, 32'hC0DE_0003,
                3'b010, 3'b000, 32'h5555_0444, 32'hC0DE_0003, 1'b1);
        add_row(1'b1, 5'd7, 32'h7777_0007, 5'd0, 5'd7, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b100, 3'b000, 32'h0, 32'h7777_0007, 1'b1);
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd6, 2'b10, 5'd9, 32'h0, 5'd0, 32'h0,
                3'b001, 3'b000, 32'h5555_0444, 32'h0000_0606, 1'b0); // Load, no match
        add_row(1'b0, 5'd0, 32'h0, 5'd0, 5'd0, 2'b10, 5'd0, 32'h1, 5'd0, 32'h2,
                3'b011, 3'b000, 32'h0, 32'h0, 1'b0); // Zero sources never stall
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b10, 5'd5, 32'h1234_5678, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h1234_5678, 32'h7777_0007, 1'b0);
        add_row(1'b0, 5'd5, 32'hEEEE_EEEE, 5'd5, 5'd0, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b100, 3'b000, 32'h5555_0444, 32'h0, 1'b0); // s4 idle, no hit
        // CSR in each stage
        add_row(1'b0, 5'd0, 32'h0, 5'd1, 5'd2, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b001, 32'h0, 32'h0, 1'b1);
        add_row(1'b0, 5'd0, 32'h0, 5'd1, 5'd2, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b010, 32'h0, 32'h0, 1'b1);
        add_row(1'b0, 5'd0, 32'h0, 5'd1, 5'd2, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b100, 32'h0, 32'h0, 1'b1);
        // Empty decode
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b00, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h5555_0444, 32'h7777_0007, 1'b1);
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b01, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h5555_0444, 32'h7777_0007, 1'b0);
        add_row(1'b0, 5'd0, 32'h0, 5'd5, 5'd7, 2'b11, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'h5555_0444, 32'h7777_0007, 1'b0);
        // Top register
        add_row(1'b1, 5'd31, 32'hFFFF_001F, 5'd31, 5'd31, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'hFFFF_001F, 32'hFFFF_001F, 1'b0);
        add_row(1'b0, 5'd0, 32'h0, 5'd31, 5'd5, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                3'b000, 3'b000, 32'hFFFF_001F, 32'h5555_0444, 1'b0);
    endtask

    // --------------------
    // Watchdog

    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + 10) * CLK_PERIOD);
        abort_run("Timeout: the stimulus table did not finish in time");
    end

    // --------------------
    // Main sequence

    initial begin
        rst = 1'b1;
        apply_row('{1'b0, 5'd0, 32'h0, 5'd0, 5'd0, 2'b10, 5'd0, 32'h0, 5'd0, 32'h0,
                    3'b000, 3'b000, 32'h0, 32'h0, 1'b0}); // Quiet inputs during reset
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge g_clk);
        for (int i = 0; i < rows.size(); i++) begin
            #(DRIVE_DELAY);
            rst = 1'b0; // Released with the first row
            apply_row(rows[i]);
            #(CHECK_DELAY);
            check_word("rs1_data", rs1_data, rows[i].exp_rs1, i);
            check_word("rs2_data", rs2_data, rows[i].exp_rs2, i);
            check_bit("bubble", bubble, rows[i].exp_bubble, i);
            @(posedge g_clk);
        end
        $display("%0d rows checked", rows.size());
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
